//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = tb_core
FILELIST = src.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))
DATA     = verif/core_input.txt

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN) $(DATA)
	./$(BIN) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- hw/core_top.sv
// ----------------------------
// core_top
// two-stage RV32I subset core with program
// load port and commit report
// ----------------------------
`timescale 1ns/100ps

module core_top #(
  parameter logic [31:0] RESET_PC = 32'h0,
  parameter int IMEM_WORDS = 64,
  parameter logic [31:0] MTVEC_RESET = 32'h80
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          load_en,
  input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
  input  logic [31:0]                   load_data,
  output logic                          commit_valid,
  output logic [31:0]                   commit_pc,
  output logic [31:0]                   commit_inst,
  output logic                          commit_wen,
  output logic [4:0]                    commit_wdest,
  output logic [31:0]                   commit_wdata,
  output logic                          commit_trap
);
  import isa_pkg::*;

  // fetch to execute
  logic        fetch_valid;
  logic [31:0] fetch_pc;
  inst_word_t  fetch_inst;

  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        rd_wen;
  logic [4:0]  rd_addr;
  logic [31:0] rd_data;

  logic [11:0] csr_addr;
  logic        csr_wen;
  logic [31:0] csr_wdata;
  logic [31:0] csr_rdata;

  logic        exec_valid;
  logic        ecall;
  logic        mret;
  logic        illegal;
  logic [31:0] exec_pc;

  logic        trap_enter;
  logic [31:0] trap_cause;
  logic [31:0] trap_pc;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic        redirect;
  logic [31:0] redirect_pc;

  fetch_unit #(
    .RESET_PC   (RESET_PC),
    .IMEM_WORDS (IMEM_WORDS)
  ) u_fetch (
    .clock       (clock),
    .reset       (reset),
    .load_en     (load_en),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_inst  (fetch_inst)
  );

  regfile u_regfile (
    .clock    (clock),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_wen   (rd_wen),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  exec_unit u_exec (
    .clock        (clock),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .fetch_inst   (fetch_inst),
    .rs1          (rs1),
    .rs2          (rs2),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .rd_wen       (rd_wen),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .csr_addr     (csr_addr),
    .csr_wen      (csr_wen),
    .csr_wdata    (csr_wdata),
    .csr_rdata    (csr_rdata),
    .exec_valid   (exec_valid),
    .ecall        (ecall),
    .mret         (mret),
    .illegal      (illegal),
    .exec_pc      (exec_pc),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_inst  (commit_inst),
    .commit_wen   (commit_wen),
    .commit_wdest (commit_wdest),
    .commit_wdata (commit_wdata),
    .commit_trap  (commit_trap)
  );

  csr_file #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_csr (
    .clock      (clock),
    .reset      (reset),
    .csr_addr   (csr_addr),
    .csr_wen    (csr_wen),
    .csr_wdata  (csr_wdata),
    .csr_rdata  (csr_rdata),
    .trap_enter (trap_enter),
    .trap_cause (trap_cause),
    .trap_pc    (trap_pc),
    .mtvec      (mtvec),
    .mepc       (mepc)
  );

  trap_unit u_trap (
    .exec_valid  (exec_valid),
    .ecall       (ecall),
    .mret        (mret),
    .illegal     (illegal),
    .exec_pc     (exec_pc),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .trap_enter  (trap_enter),
    .trap_cause  (trap_cause),
    .trap_pc     (trap_pc),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

endmodule

//--- hw/csr_file.sv
// ----------------------------
// csr_file
// machine CSRs with software access
// and trap-entry updates
// ----------------------------
`timescale 1ns/100ps

module csr_file #(
  parameter logic [31:0] MTVEC_RESET = 32'h80
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [11:0] csr_addr,
  input  logic        csr_wen,
  input  logic [31:0] csr_wdata,
  output logic [31:0] csr_rdata,
  input  logic        trap_enter,
  input  logic [31:0] trap_cause,
  input  logic [31:0] trap_pc,
  output logic [31:0] mtvec,
  output logic [31:0] mepc
);
  import csr_pkg::*;

  csr_sel_t    sel;
  logic [31:0] mscratch;
  logic [31:0] mcause;

  always_comb begin
    case (csr_addr)
      CSR_MSCRATCH: sel = SEL_MSCRATCH;
      CSR_MEPC:     sel = SEL_MEPC;
      CSR_MCAUSE:   sel = SEL_MCAUSE;
      CSR_MTVEC:    sel = SEL_MTVEC;
      default:      sel = SEL_NONE;
    endcase
  end

  always_comb begin
    case (sel)
      SEL_MSCRATCH: csr_rdata = mscratch;
      SEL_MEPC:     csr_rdata = mepc;
      SEL_MCAUSE:   csr_rdata = mcause;
      SEL_MTVEC:    csr_rdata = mtvec;
      default:      csr_rdata = 32'h0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mscratch <= 32'h0;
      mepc <= 32'h0;
      mcause <= 32'h0;
      mtvec <= MTVEC_RESET;
    end else if (trap_enter) begin
      // trap entry wins over a software write
      mepc <= trap_pc;
      mcause <= trap_cause;
    end else if (csr_wen) begin
      case (sel)
        SEL_MSCRATCH: mscratch <= csr_wdata;
        SEL_MEPC:     mepc <= {csr_wdata[31:2], 2'b00};
        SEL_MCAUSE:   mcause <= csr_wdata;
        // direct mode only
        SEL_MTVEC:    mtvec <= {csr_wdata[31:2], 2'b00};
        default:      ;
      endcase
    end
  end

endmodule

//--- hw/csr_pkg.sv
// ----------------------------
// csr_pkg
// machine CSR addresses, trap causes and
// the CSR selector
// ----------------------------
package csr_pkg;

  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;

  localparam logic [31:0] CAUSE_ILLEGAL = 32'd2;
  localparam logic [31:0] CAUSE_ECALL_M = 32'd11;

  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_MSCRATCH,
    SEL_MEPC,
    SEL_MCAUSE,
    SEL_MTVEC
  } csr_sel_t;

endpackage

//--- hw/exec_unit.sv
// ----------------------------
// exec_unit
// decode, ALU, write-back select and the
// registered commit report
// ----------------------------
`timescale 1ns/100ps

module exec_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                fetch_valid,
  input  logic [31:0]         fetch_pc,
  input  isa_pkg::inst_word_t fetch_inst,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  input  logic [31:0]         rs1_data,
  input  logic [31:0]         rs2_data,
  output logic                rd_wen,
  output logic [4:0]          rd_addr,
  output logic [31:0]         rd_data,
  output logic [11:0]         csr_addr,
  output logic                csr_wen,
  output logic [31:0]         csr_wdata,
  input  logic [31:0]         csr_rdata,
  output logic                exec_valid,
  output logic                ecall,
  output logic                mret,
  output logic                illegal,
  output logic [31:0]         exec_pc,
  output logic                commit_valid,
  output logic [31:0]         commit_pc,
  output logic [31:0]         commit_inst,
  output logic                commit_wen,
  output logic [4:0]          commit_wdest,
  output logic [31:0]         commit_wdata,
  output logic                commit_trap
);
  import isa_pkg::*;
  import csr_pkg::*;

  alu_op_t     alu_op;
  logic [31:0] op_b;
  logic [31:0] alu_out;
  logic        writes_rd;
  logic        is_csr;
  logic        trap;

  assign rs1 = fetch_inst.r.rs1;
  assign rs2 = fetch_inst.r.rs2;
  assign csr_addr = fetch_inst.i.imm12;

  always_comb begin
    alu_op = ALU_ADD;
    op_b = rs2_data;
    writes_rd = 1'b0;
    is_csr = 1'b0;
    ecall = 1'b0;
    mret = 1'b0;
    illegal = 1'b0;
    case (fetch_inst.r.opcode)
      OP: begin
        writes_rd = 1'b1;
        case (fetch_inst.r.funct3)
          F3_ADD_SUB: alu_op = (fetch_inst.r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          F3_SLT:     alu_op = ALU_SLT;
          F3_XOR:     alu_op = ALU_XOR;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    illegal = 1'b1;
        endcase
        // only SUB may use the alternate funct7
        if (fetch_inst.r.funct7 != F7_BASE &&
            !(fetch_inst.r.funct7 == F7_ALT && fetch_inst.r.funct3 == F3_ADD_SUB)) begin
          illegal = 1'b1;
        end
      end
      OP_IMM: begin
        writes_rd = 1'b1;
        op_b = {{20{fetch_inst.i.imm12[11]}}, fetch_inst.i.imm12};
        illegal = (fetch_inst.i.funct3 != F3_ADD_SUB);
      end
      LUI: begin
        writes_rd = 1'b1;
        alu_op = ALU_PASS_B;
        op_b = {fetch_inst.i.imm12, fetch_inst.i.rs1, fetch_inst.i.funct3, 12'h000};
      end
      SYSTEM: begin
        if (fetch_inst.i.funct3 == F3_CSRRW) begin
          writes_rd = 1'b1;
          is_csr = 1'b1;
          // unimplemented CSRs trap
          illegal = !(fetch_inst.i.imm12 inside
                      {CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVEC});
        end else if (fetch_inst.i.funct3 == F3_PRIV &&
                     fetch_inst.i.imm12 == IMM_ECALL) begin
          ecall = 1'b1;
        end else if (fetch_inst.i.funct3 == F3_PRIV &&
                     fetch_inst.i.imm12 == IMM_MRET) begin
          mret = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
  end

  always_comb begin
    case (alu_op)
      ALU_SUB:    alu_out = rs1_data - op_b;
      ALU_AND:    alu_out = rs1_data & op_b;
      ALU_OR:     alu_out = rs1_data | op_b;
      ALU_XOR:    alu_out = rs1_data ^ op_b;
      ALU_SLT:    alu_out = {31'h0, $signed(rs1_data) < $signed(op_b)};
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = rs1_data + op_b;
    endcase
  end

  assign trap = ecall | illegal;

  assign rd_wen = fetch_valid & writes_rd & ~trap;
  assign rd_addr = fetch_inst.r.rd;
  // CSRRW returns the old CSR value
  assign rd_data = is_csr ? csr_rdata : alu_out;

  assign csr_wen = fetch_valid & is_csr & ~trap;
  assign csr_wdata = rs1_data;

  assign exec_valid = fetch_valid;
  assign exec_pc = fetch_pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= fetch_valid;
    end
  end

  always_ff @(posedge clock) begin
    commit_pc <= fetch_pc;
    commit_inst <= fetch_inst;
    commit_wen <= rd_wen;
    commit_wdest <= rd_addr;
    commit_wdata <= rd_data;
    commit_trap <= trap;
  end

endmodule

//--- hw/fetch_unit.sv
// ----------------------------
// fetch_unit
// pc, instruction memory with load port and
// the fetch-to-execute register
// ----------------------------
`timescale 1ns/100ps

module fetch_unit #(
  parameter logic [31:0] RESET_PC = 32'h0,
  parameter int IMEM_WORDS = 64
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          load_en,
  input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
  input  logic [31:0]                   load_data,
  input  logic                          redirect,
  input  logic [31:0]                   redirect_pc,
  output logic                          fetch_valid,
  output logic [31:0]                   fetch_pc,
  output isa_pkg::inst_word_t           fetch_inst
);
  import isa_pkg::*;

  localparam int AW = $clog2(IMEM_WORDS);

  inst_word_t imem [IMEM_WORDS];
  logic [31:0] pc;

  // program is loaded only while the core is held in reset
  always_ff @(posedge clock) begin
    if (reset && load_en) begin
      imem[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= RESET_PC;
      fetch_valid <= 1'b0;
    end else if (redirect) begin
      // younger instruction becomes a bubble
      pc <= redirect_pc;
      fetch_valid <= 1'b0;
    end else begin
      pc <= pc + 32'd4;
      fetch_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    fetch_pc <= pc;
    fetch_inst <= imem[pc[AW+1:2]];
  end

endmodule

//--- hw/isa_pkg.sv
// ----------------------------
// isa_pkg
// RV32I subset encodings, instruction word views
// and ALU operation codes
// ----------------------------
package isa_pkg;

  // major opcodes
  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_PRIV    = 3'b000;
  localparam logic [2:0] F3_CSRRW   = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // imm12 of the PRIV group
  localparam logic [11:0] IMM_ECALL = 12'h000;
  localparam logic [11:0] IMM_MRET  = 12'h302;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } inst_word_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_t;

endpackage

//--- hw/regfile.sv
// ----------------------------
// regfile
// 32 x 32-bit general registers, two reads
// and one write, x0 tied to zero
// ----------------------------
`timescale 1ns/100ps

module regfile (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        rd_wen,
  input  logic [4:0]  rd_addr,
  input  logic [31:0] rd_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (rd_wen && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

//--- hw/trap_unit.sv
// ----------------------------
// trap_unit
// trap entry, MRET return and the fetch
// redirect target
// ----------------------------
`timescale 1ns/100ps

module trap_unit (
  input  logic        exec_valid,
  input  logic        ecall,
  input  logic        mret,
  input  logic        illegal,
  input  logic [31:0] exec_pc,
  input  logic [31:0] mtvec,
  input  logic [31:0] mepc,
  output logic        trap_enter,
  output logic [31:0] trap_cause,
  output logic [31:0] trap_pc,
  output logic        redirect,
  output logic [31:0] redirect_pc
);
  import csr_pkg::*;

  assign trap_enter = exec_valid & (ecall | illegal);
  assign trap_cause = illegal ? CAUSE_ILLEGAL : CAUSE_ECALL_M;
  assign trap_pc = exec_pc;

  // mret only steers fetch
  assign redirect = trap_enter | (exec_valid & mret);
  assign redirect_pc = trap_enter ? mtvec : mepc;

endmodule

//--- src.f
hw/isa_pkg.sv
hw/csr_pkg.sv
hw/fetch_unit.sv
hw/regfile.sv
hw/exec_unit.sv
hw/csr_file.sv
hw/trap_unit.sv
hw/core_top.sv
verif/tb_clock_gen.sv
verif/tb_core.sv

//--- verif/core_input.txt
// program word count, then the program words from address 0
// record count, then records: pc inst wen wdest wdata trap
10
02C00093
401001B3
0011A2B3
0011F4B3
00908433
30541173
FFFFF337
003343B3
0053E533
34051073
00000073
0000000B
340015F3
34201673
341096F3
30200073
13
00000000 02C00093 1 01 0000002C 0
00000004 401001B3 1 03 FFFFFFD4 0
00000008 0011A2B3 1 05 00000001 0
0000000C 0011F4B3 1 09 00000004 0
00000010 00908433 1 08 00000030 0
00000014 30541173 1 02 00000080 0
00000018 FFFFF337 1 06 FFFFF000 0
0000001C 003343B3 1 07 00000FD4 0
00000020 0053E533 1 0A 00000FD5 0
00000024 34051073 1 00 00000000 0
00000028 00000073 0 00 00000000 1
00000030 340015F3 1 0B 00000FD5 0
00000034 34201673 1 0C 0000000B 0
00000038 341096F3 1 0D 00000028 0
0000003C 30200073 0 00 00000000 0
0000002C 0000000B 0 00 00000000 1
00000030 340015F3 1 0B 00000000 0
00000034 34201673 1 0C 00000002 0
00000038 341096F3 1 0D 0000002C 0

//--- verif/tb_clock_gen.sv
// ------------------------------
// tb_clock_gen
// testbench clock and reset source
// ------------------------------
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD = 4,
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

//--- verif/tb_core.sv
// ------------------------------
// tb_core
// loads a program into the core, checks every
// commit against expected records
// ------------------------------
`timescale 1ns/100ps

module tb_core;

  localparam int CLOCK_PERIOD = 4;
  localparam int RESET_CYCLES = 16;
  localparam int IMEM_WORDS = 64;
  localparam int STIM_DEPTH = 256;

  logic        clock;
  logic        reset;
  logic        load_en;
  logic [5:0]  load_addr;
  logic [31:0] load_data;
  logic        commit_valid;
  logic [31:0] commit_pc;
  logic [31:0] commit_inst;
  logic        commit_wen;
  logic [4:0]  commit_wdest;
  logic [31:0] commit_wdata;
  logic        commit_trap;

  logic [31:0] stim [STIM_DEPTH];
  int          num_words;
  int          num_records;
  int          rec_base;
  int          rec_idx;
  int          mismatch_count;
  int          other_count;
  logic        loaded;

  tb_clock_gen #(
    .PERIOD       (CLOCK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  core_top #(
    .RESET_PC    (32'h0),
    .IMEM_WORDS  (IMEM_WORDS),
    .MTVEC_RESET (32'h80)
  ) DUT (
    .clock        (clock),
    .reset        (reset),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_inst  (commit_inst),
    .commit_wen   (commit_wen),
    .commit_wdest (commit_wdest),
    .commit_wdata (commit_wdata),
    .commit_trap  (commit_trap)
  );

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    mismatch_count++;
    $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  task automatic check_commit();
    int base;
    base = rec_base + 6 * rec_idx;
    if (rec_idx >= num_records) begin
      other_count++;
      $display("unexpected commit at pc %h, no expected record left", commit_pc);
    end else begin
      if (commit_pc != stim[base]) begin
        report_mismatch("commit_pc", stim[base], commit_pc);
      end
      if (commit_inst != stim[base + 1]) begin
        report_mismatch("commit_inst", stim[base + 1], commit_inst);
      end
      if (commit_wen != stim[base + 2][0]) begin
        report_mismatch("commit_wen", stim[base + 2], {31'h0, commit_wen});
      end
      if (commit_trap != stim[base + 5][0]) begin
        report_mismatch("commit_trap", stim[base + 5], {31'h0, commit_trap});
      end
      // destination only means something when a write is expected
      if (stim[base + 2][0]) begin
        if (commit_wdest != stim[base + 3][4:0]) begin
          report_mismatch("commit_wdest", stim[base + 3], {27'h0, commit_wdest});
        end
        if (commit_wdata != stim[base + 4]) begin
          report_mismatch("commit_wdata", stim[base + 4], commit_wdata);
        end
      end
      rec_idx++;
    end
  endtask

  // commits are compared at the falling edge
  always @(negedge clock) begin
    if (!reset && commit_valid) begin
      check_commit();
    end
  end

  initial begin
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    rec_idx = 0;
    mismatch_count = 0;
    other_count = 0;
    loaded = 1'b0;
    $readmemh("verif/core_input.txt", stim);
    num_words = stim[0];
    num_records = stim[num_words + 1];
    rec_base = num_words + 2;
    loaded = 1'b1;
    if (num_records == 0 || rec_base + 6 * num_records > STIM_DEPTH) begin
      other_count++;
      $display("input file holds no usable expected records");
    end
    // program goes in one word per edge while reset is high
    #1;
    for (int k = 0; k < num_words; k++) begin
      if (!reset) begin
        other_count++;
        $display("program word %0d could not be loaded before reset ended", k);
      end
      load_en = 1'b1;
      load_addr = k[5:0];
      load_data = stim[1 + k];
      @(posedge clock);
      #1;
    end
    load_en = 1'b0;
    wait (rec_idx >= num_records);
    $display("errors: %0d field mismatches, %0d other failures", mismatch_count,
             other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // limit scales with the number of expected commits
  initial begin
    wait (loaded);
    #((num_records + RESET_CYCLES) * 4 * CLOCK_PERIOD);
    $display("timeout, %0d of %0d expected commits never arrived",
             num_records - rec_idx, num_records);
    $display("errors: %0d field mismatches, %0d other failures", mismatch_count,
             other_count + 1);
    $display("sim failed");
    $finish;
  end

endmodule
